// File: source/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// fetch byte address width.
`define ICACHE_ADDR_W 64

// number of sets, one line per way in each set.
`define ICACHE_SETS 64

// associativity.
`define ICACHE_WAYS 4

// line size in bytes, also the width of one refill from memory.
`define ICACHE_LINE_BYTES 16

// instruction width seen by decode.
`define ICACHE_INST_W 32

// tag = address bits above index and offset,
// i.e. 64 - 6 - 4 = 54 bits with the values above.

`endif

// File: source/icache_geom_pkg.sv
`default_nettype none

`include "icache_defines.svh"

package icache_geom_pkg;

	localparam int unsigned OFFSET_W = $clog2(`ICACHE_LINE_BYTES); // byte in line.
	localparam int unsigned INDEX_W = $clog2(`ICACHE_SETS);
	localparam int unsigned TAG_W = `ICACHE_ADDR_W - INDEX_W - OFFSET_W;

	typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
	typedef logic [TAG_W-1:0] tag_t; // bits 63:10.
	typedef logic [INDEX_W-1:0] index_t; // bits 9:4.
	typedef logic [`ICACHE_LINE_BYTES*8-1:0] line_t;
	typedef logic [`ICACHE_WAYS-1:0] way_mask_t; // one-hot or zero.

	function automatic tag_t addr_tag(addr_t a);
		return a[`ICACHE_ADDR_W-1 -: TAG_W];
	endfunction

	function automatic index_t addr_index(addr_t a);
		return a[OFFSET_W +: INDEX_W];
	endfunction

	// clears the byte offset.
	function automatic addr_t line_base(addr_t a);
		return a & ~addr_t'(`ICACHE_LINE_BYTES - 1);
	endfunction

endpackage

`default_nettype wire

// File: source/fetch_pkg.sv
`default_nettype none

`include "icache_defines.svh"

package fetch_pkg;

	localparam int unsigned WORDS = `ICACHE_LINE_BYTES * 8 / `ICACHE_INST_W; // per line.

	typedef logic [`ICACHE_INST_W-1:0] inst_t;
	typedef logic [$clog2(WORDS)-1:0] word_sel_t;

	// bits 3:2 of the fetch address.
	function automatic word_sel_t word_sel(icache_geom_pkg::addr_t a);
		return a[$clog2(`ICACHE_INST_W / 8) +: $bits(word_sel_t)];
	endfunction

	function automatic inst_t pick_word(icache_geom_pkg::line_t line, word_sel_t sel);
		return line[int'(sel) * `ICACHE_INST_W +: `ICACHE_INST_W];
	endfunction

endpackage

`default_nettype wire

// File: source/icache_way_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

// behavioural model of one way's line macro, single port.
module icache_way_sram (
	input logic clk,
	input logic en,
	input logic we,
	input icache_geom_pkg::index_t index,
	input icache_geom_pkg::line_t wdata,
	output icache_geom_pkg::line_t rdata
);

	import icache_geom_pkg::*;

	line_t mem [`ICACHE_SETS];

	// write and read share the port.
	// read data stays put while en is low.
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= wdata;
			end else begin
				rdata <= mem[index]; // valid after the edge.
			end
		end
	end

endmodule

`default_nettype wire

// File: source/icache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_tag_array (
	input logic clk,
	input logic rst,
	input icache_geom_pkg::addr_t addr,
	input logic valid,
	input logic flush,
	input logic id_ready,
	output icache_geom_pkg::way_mask_t way_hit,
	output icache_geom_pkg::way_mask_t way_en,
	output logic fill
);

	import icache_geom_pkg::*;

	tag_t tags [`ICACHE_WAYS][`ICACHE_SETS];
	way_mask_t vld [`ICACHE_SETS]; // valid bits, one per way.
	way_mask_t victim; // rotating one-hot.
	way_mask_t lookup;

	tag_t req_tag;
	index_t req_index;
	logic accept;

	assign req_tag = addr_tag(addr);
	assign req_index = addr_index(addr);
	assign accept = valid && id_ready;

	// clockless read of the tag and valid arrays.
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			lookup[w] = vld[req_index][w] && (tags[w][req_index] == req_tag);
		end
	end

	assign way_hit = accept ? lookup : '0; // only for accepted requests.
	assign fill = accept && (lookup == '0);

	// hit way reads, victim way takes the refill.
	assign way_en = !accept ? '0 : (fill ? victim : lookup);

	always_ff @(posedge clk) begin
		if (fill) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (victim[w]) begin
					tags[w][req_index] <= req_tag;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `ICACHE_SETS; s++) begin
				vld[s] <= '0;
			end
			victim <= way_mask_t'(1); // way 0.
		end else begin
			if (fill) begin
				vld[req_index] <= vld[req_index] | victim;
			end
			// steps whenever the pipe advances, valid or not.
			if (id_ready && !flush) begin
				victim <= {victim[`ICACHE_WAYS-2:0], victim[`ICACHE_WAYS-1]};
			end
		end
	end

endmodule

`default_nettype wire

// File: source/icache_resp_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_resp_stage (
	input logic clk,
	input logic rst,
	input icache_geom_pkg::addr_t addr,
	input logic valid,
	input logic flush,
	input logic id_ready,
	input icache_geom_pkg::way_mask_t way_hit,
	input icache_geom_pkg::line_t mem_line,
	input icache_geom_pkg::line_t way_data [`ICACHE_WAYS],
	output fetch_pkg::inst_t inst,
	output logic ready
);

	import icache_geom_pkg::*;
	import fetch_pkg::*;

	way_mask_t hit_q;
	line_t refill_q; // copy of the memory line for a miss.
	word_sel_t sel_q;
	line_t rd_line;
	inst_t cur_inst;
	inst_t hold_q;
	logic held;

	// control side of the response.
	always_ff @(posedge clk) begin
		if (rst) begin
			hit_q <= '0;
			ready <= 1'b0;
		end else if (id_ready) begin
			if (flush) begin
				hit_q <= '0;
				ready <= 1'b0; // drop the in-flight response.
			end else begin
				hit_q <= way_hit;
				ready <= valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (id_ready) begin
			refill_q <= mem_line;
			sel_q <= word_sel(addr);
		end
	end

	// hit way's read port, else the saved refill line.
	always_comb begin
		rd_line = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (hit_q[w]) begin
				rd_line = rd_line | way_data[w];
			end
		end
		if (hit_q == '0) begin
			rd_line = refill_q;
		end
	end

	assign cur_inst = pick_word(rd_line, sel_q);

	// freeze on the first stalled cycle, release with id_ready.
	always_ff @(posedge clk) begin
		if (rst) begin
			held <= 1'b0;
		end else begin
			held <= !id_ready;
		end
	end

	always_ff @(posedge clk) begin
		if (!id_ready && !held) begin
			hold_q <= cur_inst;
		end
	end

	assign inst = held ? hold_q : cur_inst;

endmodule

`default_nettype wire

// File: source/icache.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache (
	input logic clk,
	input logic rst,
	input icache_geom_pkg::addr_t addr,
	input logic valid,
	input logic flush,
	input logic id_ready,
	output fetch_pkg::inst_t inst,
	output logic ready,
	output icache_geom_pkg::addr_t mem_addr,
	output logic mem_req,
	input icache_geom_pkg::line_t mem_line,
	output logic hit
);

	import icache_geom_pkg::*;

	way_mask_t way_hit;
	way_mask_t way_en;
	logic fill;
	line_t way_rdata [`ICACHE_WAYS];

	assign mem_addr = line_base(addr);
	assign mem_req = fill; // refill answers in the same cycle.
	assign hit = |way_hit;

	icache_tag_array tag_array_i (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.valid(valid),
		.flush(flush),
		.id_ready(id_ready),
		.way_hit(way_hit),
		.way_en(way_en),
		.fill(fill)
	);

	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		icache_way_sram way_sram_i (
			.clk(clk),
			.en(way_en[w]),
			.we(fill), // only the victim is enabled on a miss.
			.index(addr_index(addr)),
			.wdata(mem_line),
			.rdata(way_rdata[w])
		);
	end

	icache_resp_stage resp_stage_i (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.valid(valid),
		.flush(flush),
		.id_ready(id_ready),
		.way_hit(way_hit),
		.mem_line(mem_line),
		.way_data(way_rdata),
		.inst(inst),
		.ready(ready)
	);

endmodule

`default_nettype wire

// File: dv/icache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module icache_sva (
	input logic clk,
	input logic rst,
	input icache_geom_pkg::addr_t addr,
	input logic valid,
	input logic flush,
	input logic id_ready,
	input logic ready,
	input logic mem_req,
	input logic hit,
	input fetch_pkg::inst_t inst
);

	import icache_geom_pkg::*;

	addr_t line_addr;
	int fail_count = 0;

	assign line_addr = line_base(addr);

	// a refilled line serves the next fetch from a way, with no second refill.
	a_refill_hits: assert property (@(posedge clk) disable iff (rst)
		mem_req ##1 (valid && id_ready && $stable(line_addr)) |-> (hit && !mem_req))
		else begin
			$error("refilled line did not hit on the next fetch");
			fail_count++;
		end

	a_ready_follows: assert property (@(posedge clk) disable iff (rst)
		(valid && id_ready && !flush) |=> ready)
		else begin
			$error("accepted request was not followed by ready");
			fail_count++;
		end

	// frozen output while decode holds off.
	a_inst_stable: assert property (@(posedge clk) disable iff (rst)
		(!id_ready && ready) |=> $stable(inst))
		else begin
			$error("inst changed during a stall");
			fail_count++;
		end

endmodule

bind icache icache_sva sva_i (
	.clk(clk),
	.rst(rst),
	.addr(addr),
	.valid(valid),
	.flush(flush),
	.id_ready(id_ready),
	.ready(ready),
	.mem_req(mem_req),
	.hit(hit),
	.inst(inst)
);

`default_nettype wire

// File: dv/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_tb;

	import icache_geom_pkg::*;
	import fetch_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int N_RAND = 300;
	localparam int MARGIN = 20;
	localparam int OFF_W = $clog2(`ICACHE_LINE_BYTES);
	localparam int TAG_LSB = OFF_W + $clog2(`ICACHE_SETS);
	localparam int LINE_WORDS = `ICACHE_LINE_BYTES * 8 / `ICACHE_INST_W;
	localparam inst_t MEM_SALT = 32'h5a3c_96e1;

	logic clk;
	logic rst;
	addr_t addr;
	logic valid;
	logic flush;
	logic id_ready;
	inst_t inst;
	logic ready;
	addr_t mem_addr;
	logic mem_req;
	line_t mem_line;
	logic hit;

	// reference copy of tags, valid bits and victim pointer.
	tag_t m_tag [`ICACHE_WAYS][`ICACHE_SETS];
	logic m_vld [`ICACHE_WAYS][`ICACHE_SETS];
	int m_victim;
	logic exp_ready;
	inst_t exp_inst;
	string resp_name;

	string tbl_name [$];
	addr_t tbl_addr [$];
	logic [4:0] tbl_ctl [$]; // {valid, flush, id_ready, hit, mem_req}.

	logic [31:0] lfsr;

	icache icache_i (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.valid(valid),
		.flush(flush),
		.id_ready(id_ready),
		.inst(inst),
		.ready(ready),
		.mem_addr(mem_addr),
		.mem_req(mem_req),
		.mem_line(mem_line),
		.hit(hit)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// word address folded to 32 bits and salted.
	function automatic inst_t mem_word(addr_t a);
		addr_t wa;
		wa = a >> 2;
		return inst_t'(wa) ^ inst_t'(wa >> 32) ^ MEM_SALT;
	endfunction

	function automatic line_t mem_read(addr_t base);
		line_t l;
		for (int w = 0; w < LINE_WORDS; w++) begin
			l[w * `ICACHE_INST_W +: `ICACHE_INST_W] = mem_word(base + addr_t'(4 * w));
		end
		return l;
	endfunction

	assign mem_line = mem_read(mem_addr); // answers in the same cycle.

	function automatic addr_t fetch_addr(int t, int s, int w);
		return {tag_t'(t), index_t'(s), word_sel_t'(w), 2'b00};
	endfunction

	// taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
	endtask

	task automatic stop_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s: expected %b, got %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_inst(input string name, input inst_t exp, input inst_t act);
		if (act !== exp) begin
			$display("ERR %s: expected %h, got %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			$display("ERR %s: expected %h, got %h", name, exp, act);
			stop_run();
		end
	endtask

	function automatic logic model_lookup(addr_t a);
		tag_t t;
		index_t s;
		logic found;
		t = tag_t'(a >> TAG_LSB);
		s = index_t'(a >> OFF_W);
		found = 1'b0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (m_vld[w][s] && m_tag[w][s] == t) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	// state change at the coming edge.
	task automatic update_model(input string name, input addr_t a, input logic v, input logic f,
			input logic r, input logic miss);
		index_t s;
		s = index_t'(a >> OFF_W);
		if (miss) begin
			m_tag[m_victim][s] = tag_t'(a >> TAG_LSB);
			m_vld[m_victim][s] = 1'b1;
		end
		if (r && f) begin
			exp_ready = 1'b0;
		end else if (r) begin
			exp_ready = v;
			exp_inst = v ? mem_word(a) : exp_inst;
			resp_name = v ? name : resp_name;
		end
		if (r && !f) begin
			m_victim = (m_victim + 1) % `ICACHE_WAYS;
		end
	endtask

	task automatic apply_step(input string name, input addr_t a, input logic [2:0] vfr,
			input logic from_tbl, input logic [1:0] tbl_hq);
		logic known;
		logic want_hit;
		logic want_req;
		addr <= a;
		valid <= vfr[2];
		flush <= vfr[1];
		id_ready <= vfr[0];
		@(negedge clk);
		check_flag({resp_name, " ready"}, exp_ready, ready);
		if (exp_ready) begin
			check_inst({resp_name, " inst"}, exp_inst, inst);
		end
		known = model_lookup(a);
		want_hit = vfr[2] && vfr[0] && known;
		want_req = vfr[2] && vfr[0] && !known;
		if (from_tbl) begin
			check_flag({name, " hit (table)"}, tbl_hq[1], hit);
			check_flag({name, " mem_req (table)"}, tbl_hq[0], mem_req);
		end
		check_flag({name, " hit"}, want_hit, hit);
		check_flag({name, " mem_req"}, want_req, mem_req);
		if (want_req) begin
			check_addr({name, " mem_addr"}, (a >> OFF_W) << OFF_W, mem_addr);
		end
		update_model(name, a, vfr[2], vfr[1], vfr[0], want_req);
		@(posedge clk);
	endtask

	task automatic add_row(input string n, input addr_t a, input logic [4:0] ctl);
		tbl_name.push_back(n);
		tbl_addr.push_back(a);
		tbl_ctl.push_back(ctl);
	endtask

	task automatic build_table();
		// ctl bits are valid, flush, id_ready, expected hit, expected mem_req.
		add_row("first_miss", fetch_addr('h11, 1, 0), 5'b10101);
		add_row("same_line_w1", fetch_addr('h11, 1, 1), 5'b10110);
		add_row("same_line_w2", fetch_addr('h11, 1, 2), 5'b10110);
		add_row("same_line_w3", fetch_addr('h11, 1, 3), 5'b10110);
		add_row("idle", fetch_addr(0, 0, 0), 5'b00100);
		add_row("evict_t0", fetch_addr('h21, 5, 0), 5'b10101); // victim way 1.
		add_row("evict_t1", fetch_addr('h22, 5, 1), 5'b10101);
		add_row("evict_t2", fetch_addr('h23, 5, 2), 5'b10101);
		add_row("evict_t3", fetch_addr('h24, 5, 3), 5'b10101);
		add_row("evict_t4", fetch_addr('h25, 5, 0), 5'b10101); // pushes out t0.
		add_row("refetch_t0", fetch_addr('h21, 5, 0), 5'b10101); // pushes out t1.
		add_row("refetch_t2", fetch_addr('h23, 5, 1), 5'b10110);
		add_row("refetch_t3", fetch_addr('h24, 5, 2), 5'b10110);
		add_row("refetch_t4", fetch_addr('h25, 5, 3), 5'b10110);
		add_row("refetch_t1", fetch_addr('h22, 5, 0), 5'b10101);
		add_row("pre_stall", fetch_addr('h11, 1, 2), 5'b10110);
		add_row("stall_0", fetch_addr('h33, 1, 0), 5'b10000);
		add_row("stall_1", fetch_addr('h33, 1, 0), 5'b10000);
		add_row("stall_2", fetch_addr('h33, 1, 0), 5'b10000);
		add_row("stall_release", fetch_addr('h11, 1, 3), 5'b10110);
		add_row("flush_miss", fetch_addr('h41, 9, 1), 5'b11101);
		add_row("after_flush", fetch_addr(0, 0, 0), 5'b00100);
		add_row("flush_refetch", fetch_addr('h41, 9, 1), 5'b10110);
		add_row("flush_hit", fetch_addr('h11, 1, 0), 5'b11110);
		add_row("tail_idle", fetch_addr(0, 0, 0), 5'b00100);
	endtask

	initial begin
		logic [31:0] r_tag;
		logic [31:0] r_set;
		logic [31:0] r_word;
		logic [31:0] r_v;
		logic [31:0] r_r;
		logic [31:0] r_f;
		clk = 1'b0;
		rst = 1'b1;
		addr = '0;
		valid = 1'b0;
		flush = 1'b0;
		id_ready = 1'b1;
		lfsr = 32'h8b55dde7;
		m_victim = 0;
		exp_ready = 1'b0;
		exp_inst = '0;
		resp_name = "reset";
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			for (int s = 0; s < `ICACHE_SETS; s++) begin
				m_vld[w][s] = 1'b0;
			end
		end
		build_table();
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < tbl_name.size(); i++) begin
			apply_step(tbl_name[i], tbl_addr[i], tbl_ctl[i][4:2], 1'b1, tbl_ctl[i][1:0]);
		end
		// eight tags over four sets, so ways get evicted.
		for (int i = 0; i < N_RAND; i++) begin
			take_bits(3, r_tag);
			take_bits(2, r_set);
			take_bits(2, r_word);
			take_bits(3, r_v);
			take_bits(2, r_r);
			take_bits(3, r_f);
			apply_step($sformatf("rand_%0d", i), fetch_addr(96 + r_tag, 12 + r_set, r_word),
				{r_v != 0, r_f == 0, r_r != 0}, 1'b0, 2'b00);
		end
		apply_step("drain", '0, 3'b001, 1'b0, 2'b00); // checks the last response.
		@(negedge clk); // assertions of the last edge have run.
		if (icache_i.sva_i.fail_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		longint limit;
		#1;
		limit = longint'(RESET_CYCLES + tbl_name.size() + N_RAND + 1 + MARGIN) * CLK_PERIOD;
		#(limit);
		$display("timeout: the test sequence did not complete within %0d ns", limit);
		stop_run();
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+source
source/icache_geom_pkg.sv
source/fetch_pkg.sv
source/icache_way_sram.sv
source/icache_tag_array.sv
source/icache_resp_stage.sv
source/icache.sv
dv/icache_sva.sv
dv/icache_tb.sv

// File: Bender.yml
package:
  name: icache

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/icache_geom_pkg.sv
      - source/fetch_pkg.sv
      - source/icache_way_sram.sv
      - source/icache_tag_array.sv
      - source/icache_resp_stage.sv
      - source/icache.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/icache_sva.sv
      - dv/icache_tb.sv
